//--- rtl/wi23_consts.svh
`ifndef WI23_CONSTS_SVH
`define WI23_CONSTS_SVH

// Register index width, 8 registers per file
`define REGFILE_DEPTH 3

`define WORD_W 16 // Instruction word width
`define OPC_W 5 // Opcode field width

// Cycles an FP divide keeps FEX occupied
`define FDIV_CYCLES 4

`endif

//--- rtl/wi23_defs.sv
`include "wi23_consts.svh"

package wi23_defs;

  typedef logic [`REGFILE_DEPTH-1:0] reg_idx_t;

  // Word layout is opcode [15:11], rd [10:8], rs [7:5], rt [4:2]
  typedef logic [`WORD_W-1:0] instr_t;

  typedef enum logic [`OPC_W-1:0] {
    OP_NOP      = 5'd0,
    OP_ALU      = 5'd1,
    OP_LOAD     = 5'd2,
    OP_STORE    = 5'd3,
    OP_BRANCH   = 5'd4,
    OP_FADD     = 5'd5,
    OP_FDIV     = 5'd6,
    OP_FCVT_INT = 5'd7, // FP op with an integer destination
    OP_FSTORE   = 5'd8
  } opcode_e;

  typedef enum logic [1:0] {
    FEX_IDLE = 2'd0,
    FEX_DIV  = 2'd1,
    FEX_LAST = 2'd2
  } fex_state_e;

  // Decoded view of the instruction held in IF_ID
  typedef struct packed {
    reg_idx_t   reg1;
    reg_idx_t   reg2;
    reg_idx_t   dest;
    logic       regw;
    logic       is_branch;
    logic       is_load;
    logic       is_fp_ex;
    logic       is_fp_store;
    logic       is_fdiv;
    logic [1:0] FPIntCvtReg; // Bit 1 integer file, bit 0 FP file
  } decoded_t;

  // Control for one FP stage
  typedef struct packed {
    logic       regw;
    reg_idx_t   regw_idx;
    logic       FpInst;
    logic [1:0] FPIntCvtReg;
  } stage_ctrl_t;

  typedef struct packed {
    logic     regw;
    reg_idx_t regw_idx;
    logic     is_load;
  } int_stage_t;

endpackage

//--- rtl/if_id_decoder.sv
`timescale 1ns/1ps
`include "wi23_consts.svh"

module if_id_decoder (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  wi23_defs::instr_t   instr,
  input  logic                stall,
  output wi23_defs::decoded_t id_dec,
  output logic                id_valid
);
  import wi23_defs::*;

  // Top bit of each register field
  localparam int RD_HI = `WORD_W - `OPC_W - 1;
  localparam int RS_HI = RD_HI - `REGFILE_DEPTH;
  localparam int RT_HI = RS_HI - `REGFILE_DEPTH;

  instr_t   if_id_instr;
  opcode_e  opcode;
  reg_idx_t rd;
  reg_idx_t rs;
  reg_idx_t rt;

  // IF_ID holds its word while stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_instr <= '0; // NOP
      id_valid    <= 1'b0;
    end else if (!stall) begin
      if_id_instr <= instr_valid ? instr : '0;
      id_valid    <= instr_valid;
    end
  end

  assign opcode = opcode_e'(if_id_instr[`WORD_W-1 -: `OPC_W]);
  assign rd     = if_id_instr[RD_HI -: `REGFILE_DEPTH];
  assign rs     = if_id_instr[RS_HI -: `REGFILE_DEPTH];
  assign rt     = if_id_instr[RT_HI -: `REGFILE_DEPTH];

  // Single-source ops repeat rs on reg2
  always_comb begin
    id_dec = '0;
    case (opcode)
      OP_ALU: begin
        id_dec.reg1 = rs;
        id_dec.reg2 = rt;
        id_dec.dest = rd;
        id_dec.regw = 1'b1;
      end
      OP_LOAD: begin
        id_dec.reg1    = rs; // Base address
        id_dec.reg2    = rs;
        id_dec.dest    = rd;
        id_dec.regw    = 1'b1;
        id_dec.is_load = 1'b1;
      end
      OP_STORE: begin
        id_dec.reg1 = rs;
        id_dec.reg2 = rt; // Store data
      end
      OP_BRANCH: begin
        id_dec.reg1      = rs;
        id_dec.reg2      = rt;
        id_dec.is_branch = 1'b1;
      end
      OP_FADD, OP_FDIV: begin
        id_dec.reg1        = rs;
        id_dec.reg2        = rt;
        id_dec.dest        = rd;
        id_dec.regw        = 1'b1;
        id_dec.is_fp_ex    = 1'b1;
        id_dec.is_fdiv     = (opcode == OP_FDIV);
        id_dec.FPIntCvtReg = 2'b01;
      end
      OP_FCVT_INT: begin
        id_dec.reg1        = rs;
        id_dec.reg2        = rs;
        id_dec.dest        = rd;
        id_dec.regw        = 1'b1;
        id_dec.is_fp_ex    = 1'b1;
        id_dec.FPIntCvtReg = 2'b10; // Result lands in the integer file
      end
      OP_FSTORE: begin
        id_dec.reg1        = rs;
        id_dec.reg2        = rt;
        id_dec.is_fp_store = 1'b1;
      end
      default: id_dec = '0; // NOP and unused opcodes
    endcase
  end

  // The source repeats its word for every stalled cycle
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable({instr_valid, instr}));

endmodule

//--- rtl/hazard.sv
`timescale 1ns/1ps

module hazard (
  input  logic                   clk,
  input  wi23_defs::decoded_t    id_dec,
  input  wi23_defs::int_stage_t  id_ex,
  input  wi23_defs::int_stage_t  ex_mem,
  input  wi23_defs::stage_ctrl_t id_fex,
  input  wi23_defs::stage_ctrl_t id_fex2,
  input  logic                   FEX_busy,
  input  logic                   FEX_busy_er,
  output logic                   stall
);

  logic if_ex_hazard;
  logic if_mem_hazard;
  logic id_fex_hazard;
  logic id_fex2_hazard;
  logic if_fex_hazard;

  // Producer in EX writes a register read in ID
  assign if_ex_hazard = id_ex.regw &
                        ((id_dec.reg1 == id_ex.regw_idx) | (id_dec.reg2 == id_ex.regw_idx));

  assign if_mem_hazard = ex_mem.regw &
                         ((id_dec.reg1 == ex_mem.regw_idx) | (id_dec.reg2 == ex_mem.regw_idx));

  assign id_fex_hazard = id_fex.regw & id_fex.FpInst &
                         ((id_dec.reg1 == id_fex.regw_idx) | (id_dec.reg2 == id_fex.regw_idx));

  assign id_fex2_hazard = id_fex2.regw & id_fex2.FpInst &
                          ((id_dec.reg1 == id_fex2.regw_idx) |
                           (id_dec.reg2 == id_fex2.regw_idx));

  // Load result needed by the op entering FEX or EX
  assign if_fex_hazard = (id_ex.regw | id_fex.FpInst) &
                         ((id_dec.reg1 == id_ex.regw_idx) | (id_dec.reg2 == id_ex.regw_idx));

  always_comb begin
    stall = (id_dec.is_branch & (if_ex_hazard | if_mem_hazard |
                                 (id_fex_hazard & id_fex.FPIntCvtReg[1]) |
                                 (id_fex2_hazard & id_fex2.FPIntCvtReg[1])))
          | (id_ex.is_load & (if_ex_hazard | if_fex_hazard))  // Load-use
          | (FEX_busy & id_dec.is_fp_ex & ~FEX_busy_er)       // FEX occupied by a divide
          | (id_fex_hazard & id_fex.FPIntCvtReg[1])           // FP result into integer file
          | (id_fex_hazard & id_dec.is_fp_store);             // FP store of a pending result
  end

  // Early release only happens inside a busy window
  a_er_in_busy: assert property (@(posedge clk) FEX_busy_er |-> FEX_busy);

endmodule

//--- rtl/pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker (
  input  logic                   clk,
  input  logic                   reset,
  input  wi23_defs::decoded_t    id_dec,
  input  logic                   id_valid,
  input  logic                   stall,
  output wi23_defs::int_stage_t  id_ex,
  output wi23_defs::int_stage_t  ex_mem,
  output wi23_defs::stage_ctrl_t id_fex,
  output wi23_defs::stage_ctrl_t id_fex2,
  output logic                   fdiv_start
);
  import wi23_defs::*;

  logic        int_take;
  logic        fp_take;
  int_stage_t  ex_next;
  stage_ctrl_t fex_next;

  // Stall turns the issuing slot into a bubble
  assign int_take = id_valid & ~stall & ~id_dec.is_fp_ex;
  assign fp_take  = id_valid & ~stall & id_dec.is_fp_ex;

  always_comb begin
    ex_next = '0;
    if (int_take) begin
      ex_next.regw     = id_dec.regw;
      ex_next.regw_idx = id_dec.dest;
      ex_next.is_load  = id_dec.is_load;
    end
  end

  always_comb begin
    fex_next = '0;
    if (fp_take) begin
      fex_next.regw        = id_dec.regw;
      fex_next.regw_idx    = id_dec.dest;
      fex_next.FpInst      = 1'b1;
      fex_next.FPIntCvtReg = id_dec.FPIntCvtReg;
    end
  end

  // Older stages advance regardless of stall
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex   <= '0;
      ex_mem  <= '0;
      id_fex  <= '0;
      id_fex2 <= '0;
    end else begin
      id_ex   <= ex_next;
      ex_mem  <= id_ex;   // Retires after MEM
      id_fex  <= fex_next;
      id_fex2 <= id_fex;  // Retires after FEX2
    end
  end

  assign fdiv_start = fp_take & id_dec.is_fdiv; // Same edge the divide enters ID_FEX

  // One issue per cycle, never into both lanes
  a_one_lane: assert property (@(posedge clk) disable iff (reset)
    id_fex.FpInst |-> (id_ex == '0));

endmodule

//--- rtl/fex_divider.sv
`timescale 1ns/1ps
`include "wi23_consts.svh"

module fex_divider (
  input  logic clk,
  input  logic reset,
  input  logic fdiv_start,
  output logic FEX_busy,
  output logic FEX_busy_er
);
  import wi23_defs::*;

  localparam int CNT_W = $clog2(`FDIV_CYCLES);

  // FEX_DIV covers all busy cycles but the last one
  localparam logic [CNT_W-1:0] DIV_LOAD = CNT_W'(`FDIV_CYCLES - 2);

  fex_state_e       state;
  fex_state_e       state_next;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  always_comb begin
    state_next = state;
    cnt_next   = cnt;
    case (state)
      FEX_IDLE: begin
        if (fdiv_start) begin
          state_next = FEX_DIV;
          cnt_next   = DIV_LOAD;
        end
      end
      FEX_DIV: begin
        if (cnt == '0) begin
          state_next = FEX_LAST;
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end
      FEX_LAST: begin
        // A divide released by busy_er may start back to back
        if (fdiv_start) begin
          state_next = FEX_DIV;
          cnt_next   = DIV_LOAD;
        end else begin
          state_next = FEX_IDLE;
        end
      end
      default: state_next = FEX_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FEX_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      cnt   <= cnt_next;
    end
  end

  assign FEX_busy    = (state != FEX_IDLE);
  assign FEX_busy_er = (state == FEX_LAST); // Last busy cycle

  // Hazard unit must hold back FP ops mid divide
  a_no_start_in_div: assert property (@(posedge clk) disable iff (reset)
    fdiv_start |-> (state != FEX_DIV));

endmodule

//--- rtl/issue_top.sv
`timescale 1ns/1ps

module issue_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  wi23_defs::instr_t      instr,
  output logic                   stall,
  output wi23_defs::int_stage_t  ex_issue,
  output wi23_defs::stage_ctrl_t fex_issue
);
  import wi23_defs::*;

  decoded_t    id_dec;
  logic        id_valid;
  int_stage_t  id_ex;
  int_stage_t  ex_mem;
  stage_ctrl_t id_fex;
  stage_ctrl_t id_fex2;
  logic        fdiv_start;
  logic        FEX_busy;
  logic        FEX_busy_er;

  if_id_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .id_dec      (id_dec),
    .id_valid    (id_valid)
  );

  pipe_tracker u_tracker (
    .clk        (clk),
    .reset      (reset),
    .id_dec     (id_dec),
    .id_valid   (id_valid),
    .stall      (stall),
    .id_ex      (id_ex),
    .ex_mem     (ex_mem),
    .id_fex     (id_fex),
    .id_fex2    (id_fex2),
    .fdiv_start (fdiv_start)
  );

  fex_divider u_divider (
    .clk         (clk),
    .reset       (reset),
    .fdiv_start  (fdiv_start),
    .FEX_busy    (FEX_busy),
    .FEX_busy_er (FEX_busy_er)
  );

  hazard u_hazard (
    .clk         (clk),
    .id_dec      (id_dec),
    .id_ex       (id_ex),
    .ex_mem      (ex_mem),
    .id_fex      (id_fex),
    .id_fex2     (id_fex2),
    .FEX_busy    (FEX_busy),
    .FEX_busy_er (FEX_busy_er),
    .stall       (stall)
  );

  // Stage just entered on each lane
  assign ex_issue  = id_ex;
  assign fex_issue = id_fex;

endmodule

//--- tests/tb_issue_top.sv
`timescale 1ns/1ps

module tb_issue_top;
  import wi23_defs::*;

  localparam int MAX_LINES       = 64;
  localparam int COLS            = 6; // valid, instr, stall, ex, fex, test id
  localparam int RELEASE_TIMEOUT = 20;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  instr_t      instr;
  logic        stall;
  int_stage_t  ex_issue;
  stage_ctrl_t fex_issue;

  logic [15:0] gold [0:MAX_LINES*COLS-1];
  logic        released;

  int checks;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;

  issue_top uut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .ex_issue    (ex_issue),
    .fex_issue   (fex_issue)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s passed", name);
    end else begin
      tests_failed++;
      $display("%s failed with %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Sampled on the falling edge, away from the input updates
  task automatic wait_for_release(output logic ok);
    int cycles;
    cycles = 0;
    while (stall && cycles < RELEASE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = !stall;
  endtask

  // One golden line per clock, outputs compared in the same cycle
  task automatic run_lines();
    int          line;
    int          base;
    logic [15:0] tid;
    line = 0;
    base = 0;
    while (line < MAX_LINES && gold[base+5] != 16'h0) begin
      tid = gold[base+5];
      @(posedge clk);
      instr_valid <= gold[base][0];
      instr       <= gold[base+1];
      @(negedge clk);
      check_value("stall", 16'(stall), gold[base+2]);
      check_value("ex_issue", 16'(ex_issue), gold[base+3]);
      check_value("fex_issue", 16'(fex_issue), gold[base+4]);
      line++;
      base = line * COLS;
      if (line == MAX_LINES || gold[base+5] != tid) begin
        end_test($sformatf("Golden test %0d", tid));
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    $readmemh("tests/issue_golden.txt", gold);

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    // Pipeline is empty straight out of reset
    check_value("stall", 16'(stall), 16'h0);
    check_value("ex_issue", 16'(ex_issue), 16'h0);
    check_value("fex_issue", 16'(fex_issue), 16'h0);
    end_test("Reset state");

    wait_for_release(released);
    if (released) begin
      run_lines();
    end else begin
      errors++;
      $display("Timeout: stall did not go low after reset");
    end

    $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tests/issue_golden.txt
// Columns in hex: instr_valid instr stall ex_issue fex_issue test_id, one line per clock
// Outputs belong to the cycle the inputs are driven in; test_id 0 ends the data
1 1140 0 00 00 1
1 0b30 0 00 00 1
1 0ddc 1 13 00 1
1 0ddc 0 00 00 1
0 0000 0 16 00 1
0 0000 0 1a 00 1
0 0000 0 00 00 1
1 0a70 0 00 00 2
1 2054 0 00 00 2
0 0000 1 14 00 2
0 0000 1 00 00 2
0 0000 0 00 00 2
1 0a70 0 00 00 2
1 20dc 0 00 00 2
0 0000 0 14 00 2
0 0000 0 00 00 2
0 0000 0 00 00 2
1 3b20 0 00 00 3
1 0c74 0 00 00 3
0 0000 1 00 5e 3
0 0000 0 00 00 3
1 2b28 0 18 00 3
1 0c74 0 00 00 3
0 0000 0 00 5d 3
0 0000 0 18 00 3
0 0000 0 00 00 3
1 2a94 0 00 00 4
1 40c8 0 00 00 4
1 0ddc 1 00 55 4
1 0ddc 0 00 00 4
0 0000 0 00 00 4
0 0000 0 1a 00 4
0 0000 0 00 00 4
1 314c 0 00 00 5
1 2ddc 0 00 00 5
0 0000 1 00 4d 5
0 0000 1 00 00 5
0 0000 1 00 00 5
0 0000 0 00 00 5
0 0000 0 00 6d 5
0 0000 0 00 00 5
1 0a70 0 00 00 6
1 0ddc 0 00 00 6
1 09dc 0 14 00 6
1 0e70 0 1a 00 6
0 0000 0 12 00 6
0 0000 0 1c 00 6
0 0000 0 00 00 6
0 0000 0 00 00 0

//--- tb.f
+incdir+rtl
rtl/wi23_defs.sv
rtl/if_id_decoder.sv
rtl/hazard.sv
rtl/pipe_tracker.sv
rtl/fex_divider.sv
rtl/issue_top.sv
tests/tb_issue_top.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_top -f tb.f -o sim_issue \
  && ./obj_dir/sim_issue > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || grep -q '\*\* PASS \*\*' sim.log
